//--- common/clk_pkg.sv
// Shared types for the clock and reset unit, imported by every block of the subsystem
package clk_pkg;

	// T-state number within a machine cycle
	typedef logic [1:0] phase_t;

	// Bus address and bus byte
	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	// Readable divider register value
	typedef logic [7:0] div_t;

	// One-clock phase strobes, one per T-state
	typedef struct packed {
		logic adr;   // T0, address out
		logic data;  // T1, read window open
		logic latch; // T2, byte captured
		logic inc;   // T3, pc advance
		logic main;  // T3, only while the oscillator runs
	} phase_stb_t;

	// One fetched byte with its address
	typedef struct packed {
		addr_t addr;
		data_t data;
	} fetch_t;

	// Reset sequencer states
	typedef enum logic [1:0] {
		HOLD,
		WAIT_STABLE,
		RUN
	} rst_state_t;

endpackage

//--- clk_gen/phase_divider.sv
// Four-phase machine-cycle divider producing one-hot phase strobes from clk_ena and osc_ena
`timescale 1ns/1ps

module phase_divider import clk_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_ena,
	input  logic       osc_ena,
	output phase_stb_t phase_stb,
	output phase_t     phase
);

	logic ena_q; // Registered clock enable

	// Phase counter steps only while the enable is seen
	always_ff @(posedge clk) begin
		if (rst) begin
			ena_q <= 1'b0;
			phase <= '0;
		end else begin
			ena_q <= clk_ena;
			if (ena_q)
				phase <= phase + 2'd1;
		end
	end

	// Strobe decode, all low while frozen
	always_comb begin
		phase_stb       = '0;
		phase_stb.adr   = ena_q && (phase == 2'd0);
		phase_stb.data  = ena_q && (phase == 2'd1);
		phase_stb.latch = ena_q && (phase == 2'd2);
		phase_stb.inc   = ena_q && (phase == 2'd3);
		phase_stb.main  = ena_q && (phase == 2'd3) && osc_ena; // No cycle end without oscillator
	end

	// Only one T-state strobe at a time
	a_stb_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({phase_stb.adr, phase_stb.data, phase_stb.latch, phase_stb.inc}))
	else $error("phase strobes not one-hot");

endmodule

//--- clk_gen/reset_sequencer.sv
// Oscillator stability tracker that releases the CPU reset after a stable period of divider ticks
`timescale 1ns/1ps

module reset_sequencer import clk_pkg::*; #(
	parameter int STABLE_TICKS = 3
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_ena,
	input  logic       osc_ena,
	input  logic       div_tick,
	input  phase_stb_t phase_stb,
	output logic       osc_stable,
	output logic       cpu_rst
);

	localparam int CNT_W = $clog2(STABLE_TICKS + 1);

	rst_state_t state;
	logic [CNT_W-1:0] tick_cnt; // Ticks seen while stable
	logic ticks_done;

	assign ticks_done = (tick_cnt == CNT_W'(STABLE_TICKS));

	// Stable flag, set by running clock and cleared by oscillator off
	always_ff @(posedge clk) begin
		if (rst)
			osc_stable <= 1'b0;
		else if (!osc_ena)
			osc_stable <= 1'b0;
		else if (clk_ena)
			osc_stable <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= HOLD;
			tick_cnt <= '0;
			cpu_rst  <= 1'b1;
		end else if (!osc_stable) begin
			state    <= HOLD; // Any loss of stability restarts the count
			tick_cnt <= '0;
			cpu_rst  <= 1'b1;
		end else begin
			case (state)
				HOLD: begin
					state    <= WAIT_STABLE;
					tick_cnt <= div_tick ? CNT_W'(1) : '0;
				end
				WAIT_STABLE: begin
					if (ticks_done) begin
						// Release only on a machine-cycle boundary
						if (phase_stb.main) begin
							state   <= RUN;
							cpu_rst <= 1'b0;
						end
					end else if (div_tick) begin
						tick_cnt <= tick_cnt + CNT_W'(1);
					end
				end
				RUN: cpu_rst <= 1'b0;
				default: state <= HOLD;
			endcase
		end
	end

	// Reset follows the stable flag down within one clock
	a_rst_on_unstable: assert property (@(posedge clk) disable iff (rst)
		!osc_stable |=> cpu_rst)
	else $error("cpu_rst low after osc_stable fell");

endmodule

//--- logic/div_counter.sv
// Machine-cycle prescaler and divider register giving the slow tick and the readable divider value
`timescale 1ns/1ps

module div_counter import clk_pkg::*; #(
	parameter int TICK_SHIFT = 2
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       div_clear,
	input  phase_stb_t phase_stb,
	output div_t       div_value,
	output logic       div_tick
);

	logic [TICK_SHIFT-1:0] presc; // Machine cycles within one tick
	logic presc_wrap;

	assign presc_wrap = phase_stb.main && (&presc);

	always_ff @(posedge clk) begin
		if (rst) begin
			presc     <= '0;
			div_value <= '0;
			div_tick  <= 1'b0;
		end else if (div_clear) begin
			presc     <= '0; // Software clear wins over counting
			div_value <= '0;
			div_tick  <= 1'b0;
		end else begin
			div_tick <= presc_wrap;
			if (phase_stb.main)
				presc <= presc + 1'b1;
			if (presc_wrap)
				div_value <= div_value + 8'd1;
		end
	end

endmodule

//--- logic/fetch_unit.sv
// Strobe-driven fetcher that puts pc on the address bus, latches the byte and publishes it per cycle
`timescale 1ns/1ps

module fetch_unit import clk_pkg::*; #(
	parameter addr_t RESET_VECTOR = 16'h0100
) (
	input  logic       clk,
	input  phase_stb_t phase_stb,
	input  logic       cpu_rst,
	input  data_t      bus_data,
	output addr_t      bus_addr,
	output logic       bus_rd,
	output fetch_t     fetch,
	output logic       fetch_valid
);

	addr_t pc;
	data_t data_q;    // Byte captured on latch
	logic  have_byte; // Latch seen in this machine cycle

	// Control path, cleared by the CPU reset
	always_ff @(posedge clk) begin
		if (cpu_rst) begin
			pc          <= RESET_VECTOR;
			bus_rd      <= 1'b0;
			have_byte   <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= phase_stb.main && have_byte;
			if (phase_stb.adr)
				bus_rd <= 1'b1; // Read window opens after T0
			else if (phase_stb.latch)
				bus_rd <= 1'b0;
			if (phase_stb.latch)
				have_byte <= 1'b1;
			else if (phase_stb.main)
				have_byte <= 1'b0;
			if (phase_stb.inc)
				pc <= pc + 16'd1;
		end
	end

	// Address and byte registers
	always_ff @(posedge clk) begin
		if (!cpu_rst && phase_stb.adr)
			bus_addr <= pc;
		if (!cpu_rst && phase_stb.latch)
			data_q <= bus_data;
		if (phase_stb.main) begin
			fetch.addr <= bus_addr;
			fetch.data <= data_q;
		end
	end

	// No fetch is published under reset
	a_no_fetch_in_rst: assert property (@(posedge clk)
		fetch_valid |-> !cpu_rst)
	else $error("fetch_valid high during cpu_rst");

endmodule

//--- logic/clk_rst_top.sv
// Top level of the clock and reset unit, setting parameters and wiring divider, reset and fetch
`timescale 1ns/1ps

module clk_rst_top import clk_pkg::*; #(
	parameter int    TICK_SHIFT   = 2,
	parameter int    STABLE_TICKS = 3,
	parameter addr_t RESET_VECTOR = 16'h0100
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_ena,
	input  logic       osc_ena,
	input  logic       div_clear,
	input  data_t      bus_data,
	output phase_stb_t phase_stb,
	output logic       osc_stable,
	output logic       cpu_rst,
	output div_t       div_value,
	output addr_t      bus_addr,
	output logic       bus_rd,
	output fetch_t     fetch,
	output logic       fetch_valid
);

	logic div_tick; // Slow tick into the stability timer

	phase_divider phase_divider_inst (
		.clk       (clk),
		.rst       (rst),
		.clk_ena   (clk_ena),
		.osc_ena   (osc_ena),
		.phase_stb (phase_stb),
		.phase     ()
	);

	div_counter #(
		.TICK_SHIFT (TICK_SHIFT)
	) div_counter_inst (
		.clk       (clk),
		.rst       (rst),
		.div_clear (div_clear),
		.phase_stb (phase_stb),
		.div_value (div_value),
		.div_tick  (div_tick)
	);

	reset_sequencer #(
		.STABLE_TICKS (STABLE_TICKS)
	) reset_sequencer_inst (
		.clk        (clk),
		.rst        (rst),
		.clk_ena    (clk_ena),
		.osc_ena    (osc_ena),
		.div_tick   (div_tick),
		.phase_stb  (phase_stb),
		.osc_stable (osc_stable),
		.cpu_rst    (cpu_rst)
	);

	fetch_unit #(
		.RESET_VECTOR (RESET_VECTOR)
	) fetch_unit_inst (
		.clk         (clk),
		.phase_stb   (phase_stb),
		.cpu_rst     (cpu_rst),
		.bus_data    (bus_data),
		.bus_addr    (bus_addr),
		.bus_rd      (bus_rd),
		.fetch       (fetch),
		.fetch_valid (fetch_valid)
	);

endmodule

//--- sim/tb_clk_rst.sv
// Self-checking testbench for the clock and reset unit, run from the project root with the trace
`timescale 1ns/1ps

module tb_clk_rst import clk_pkg::*; ();

	localparam int    TICK_SHIFT   = 2;
	localparam int    STABLE_TICKS = 3;
	localparam addr_t RESET_VECTOR = 16'h0100;

	logic       clk = 1'b0;
	logic       rst;
	logic       clk_ena;
	logic       osc_ena;
	logic       div_clear;
	data_t      bus_data;
	phase_stb_t phase_stb;
	logic       osc_stable;
	logic       cpu_rst;
	div_t       div_value;
	addr_t      bus_addr;
	logic       bus_rd;
	fetch_t     fetch;
	logic       fetch_valid;

	// Segments and expected fetches from the trace
	logic   seg_ce[$];
	logic   seg_oe[$];
	logic   seg_clr[$];
	logic   seg_rnd[$];
	int     seg_len[$];
	fetch_t exp_fetches[$];

	// Reference model state, as seen after each edge
	logic   m_ena_q;
	phase_t m_phase;
	logic   m_osc_stable;
	logic   m_cpu_rst;
	logic   m_div_tick;
	int     m_ticks;
	int     m_mains; // Main strobes since last clear
	addr_t  m_pc;
	logic   m_bus_rd;
	addr_t  m_bus_addr; // Address put out on the last adr strobe

	logic [31:0] rng = 32'h9b20_e329;
	int cycle_cnt = 0;
	int cycle_limit = 200;

	clk_rst_top #(
		.TICK_SHIFT   (TICK_SHIFT),
		.STABLE_TICKS (STABLE_TICKS),
		.RESET_VECTOR (RESET_VECTOR)
	) clk_rst_top_inst (
		.clk         (clk),
		.rst         (rst),
		.clk_ena     (clk_ena),
		.osc_ena     (osc_ena),
		.div_clear   (div_clear),
		.bus_data    (bus_data),
		.phase_stb   (phase_stb),
		.osc_stable  (osc_stable),
		.cpu_rst     (cpu_rst),
		.div_value   (div_value),
		.bus_addr    (bus_addr),
		.bus_rd      (bus_rd),
		.fetch       (fetch),
		.fetch_valid (fetch_valid)
	);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_stb(input phase_stb_t exp, input phase_stb_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t phase_stb expected=%b actual=%b", $time, exp, act);
			abort_run();
		end
	endtask

	task automatic check_fetch(input fetch_t exp, input fetch_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t fetch expected=%h/%h actual=%h/%h", $time,
				exp.addr, exp.data, act.addr, act.data);
			abort_run();
		end
	endtask

	task automatic check_div(input div_t exp, input div_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t div_value expected=%h actual=%h", $time, exp, act);
			abort_run();
		end
	endtask

	task automatic check_addr(input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t bus_addr expected=%h actual=%h", $time, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s expected=%b actual=%b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// Memory contents, low address byte XOR high address byte
	function automatic data_t mem_byte(input addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic load_trace();
		int fd;
		int n;
		int a, b, c, d, e;
		string line;
		fd = $fopen("sim/clk_rst_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file sim/clk_rst_trace.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line.getc(0) == "S") begin
				n = $sscanf(line, "S %d %d %d %d %d", a, b, c, d, e);
				seg_ce.push_back(a[0]);
				seg_oe.push_back(b[0]);
				seg_clr.push_back(c[0]);
				seg_rnd.push_back(d[0]);
				seg_len.push_back(e);
			end else if (n > 0 && line.len() > 0 && line.getc(0) == "F") begin
				n = $sscanf(line, "F %h %h", a, b);
				exp_fetches.push_back({a[15:0], b[7:0]});
			end
		end
		$fclose(fd);
	endtask

	// One strobe per enabled cycle, main only with the oscillator on
	function automatic phase_stb_t expected_stb();
		phase_stb_t s;
		s       = '0;
		s.adr   = m_ena_q && (m_phase == 2'd0);
		s.data  = m_ena_q && (m_phase == 2'd1);
		s.latch = m_ena_q && (m_phase == 2'd2);
		s.inc   = m_ena_q && (m_phase == 2'd3);
		s.main  = s.inc && osc_ena;
		return s;
	endfunction

	task automatic check_outputs();
		fetch_t exp;
		check_stb(expected_stb(), phase_stb);
		check_bit("osc_stable", m_osc_stable, osc_stable);
		check_bit("cpu_rst", m_cpu_rst, cpu_rst);
		check_div(div_t'(m_mains >> TICK_SHIFT), div_value);
		check_bit("bus_rd", m_bus_rd, bus_rd);
		if (m_bus_rd)
			check_addr(m_bus_addr, bus_addr);
		if (m_cpu_rst)
			check_bit("fetch_valid", 1'b0, fetch_valid);
		if (fetch_valid) begin
			if (exp_fetches.size() == 0) begin
				$display("A fetch from address %h came after the last expected one", fetch.addr);
				abort_run();
			end else begin
				exp = exp_fetches.pop_front();
				check_fetch(exp, fetch);
			end
		end
	endtask

	// Advance the model over the coming edge with the inputs now applied
	task automatic step_model();
		phase_stb_t s;
		logic rst_now;
		s = expected_stb();
		rst_now = m_cpu_rst;
		if (!m_osc_stable) begin
			m_ticks   = 0;
			m_cpu_rst = 1'b1;
		end else if (m_cpu_rst) begin
			if (m_ticks == STABLE_TICKS) begin
				if (s.main)
					m_cpu_rst = 1'b0; // Release at a machine-cycle end
			end else if (m_div_tick) begin
				m_ticks = m_ticks + 1;
			end
		end
		if (!osc_ena)
			m_osc_stable = 1'b0;
		else if (clk_ena)
			m_osc_stable = 1'b1;
		if (div_clear) begin
			m_div_tick = 1'b0;
			m_mains    = 0;
		end else begin
			m_div_tick = s.main && (m_mains % (1 << TICK_SHIFT) == (1 << TICK_SHIFT) - 1);
			if (s.main)
				m_mains = m_mains + 1;
		end
		// Bus side sees the CPU reset from before this edge
		if (rst_now) begin
			m_pc     = RESET_VECTOR;
			m_bus_rd = 1'b0;
		end else begin
			if (s.adr) begin
				m_bus_addr = m_pc;
				m_bus_rd   = 1'b1;
			end
			if (s.latch)
				m_bus_rd = 1'b0; // Window closes after T2
			if (s.inc)
				m_pc = m_pc + 16'd1;
		end
		if (m_ena_q)
			m_phase = m_phase + 2'd1;
		m_ena_q = clk_ena;
	endtask

	task automatic drive_cycle(input logic ce, input logic oe, input logic dc);
		@(posedge clk);
		clk_ena   <= ce;
		osc_ena   <= oe;
		div_clear <= dc;
		bus_data  <= bus_rd ? mem_byte(bus_addr) : 8'h00; // Memory answers in the read window
		@(negedge clk);
		check_outputs();
		step_model();
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	initial begin
		int total;
		int drops;
		rst          = 1'b1;
		clk_ena      = 1'b0;
		osc_ena      = 1'b0;
		div_clear    = 1'b0;
		bus_data     = 8'h00;
		m_ena_q      = 1'b0;
		m_phase      = 2'd0;
		m_osc_stable = 1'b0;
		m_cpu_rst    = 1'b1;
		m_div_tick   = 1'b0;
		m_ticks      = 0;
		m_mains      = 0;
		m_pc         = RESET_VECTOR;
		m_bus_rd     = 1'b0;
		m_bus_addr   = '0;
		load_trace();
		total = 0;
		foreach (seg_len[i])
			total = total + seg_len[i];
		cycle_limit = total + 200;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int s = 0; s < seg_len.size(); s++) begin
			for (int i = 0; i < seg_len[s]; i++) begin
				drive_cycle(seg_ce[s], seg_oe[s], seg_clr[s]);
				// Short enable gaps inside a segment, never at its last cycle
				if (seg_rnd[s] && seg_ce[s] && i < seg_len[s] - 1) begin
					rng = next_random(rng);
					if (rng[1:0] == 2'd0) begin
						drops = int'(rng[9:8]) % 3 + 1;
						repeat (drops) drive_cycle(1'b0, seg_oe[s], seg_clr[s]);
					end
				end
			end
		end
		if (exp_fetches.size() != 0) begin
			$display("%0d expected fetches never appeared", exp_fetches.size());
			abort_run();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- sim/clk_rst_trace.txt
# S clk_ena osc_ena div_clear rnd cycles : stimulus segment, rnd 1 allows random clk_ena gaps
# F addr byte (hex) : expected fetch record, in order of appearance
S 0 0 0 0 6
S 1 0 0 1 12
S 1 1 0 0 64
F 0100 01
F 0101 00
F 0102 03
F 0103 02
S 1 1 1 0 2
S 1 1 0 1 24
F 0104 05
F 0105 04
F 0106 07
F 0107 06
F 0108 09
F 0109 08
S 1 0 0 0 12
S 1 1 0 0 56
F 0100 01
F 0101 00
F 0102 03
S 0 1 0 0 4

//--- sources.f
common/clk_pkg.sv
clk_gen/phase_divider.sv
clk_gen/reset_sequencer.sv
logic/div_counter.sv
logic/fetch_unit.sv
logic/clk_rst_top.sv
sim/tb_clk_rst.sv

//--- Makefile
# Verilator build and run for the clock and reset unit testbench

VERILATOR ?= verilator
TOP       ?= tb_clk_rst
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
